//--- renkon_testdata.txt
# one job per line, all fields in hex
# total_in total_out img_size conv_kern in_offset out_offset net_offset
2 3 5 3 010 200 040
3 a 6 3 100 400 100
1 8 4 1 000 800 300
2 11 4 2 300 a00 500
1 5 7 5 ff8 ff0 7f0
4 2 3 2 020 c00 000

//--- flist.f
renkon_pkg.sv
renkon_ctrl_pkg.sv
renkon_ctrl_seq.sv
renkon_ctrl_net.sv
renkon_ctrl_input.sv
renkon_ctrl_output.sv
renkon_ctrl_core.sv
renkon_ctrl_props.sv
tb_renkon_ctrl.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_renkon_ctrl
FLIST     := flist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) | tee /dev/stderr | grep -q '^=== PASS ===$$'

clean:
	rm -rf $(OBJ_DIR)

//--- tb_renkon_ctrl.sv
`timescale 1ns/1ps

module tb_renkon_ctrl
  import renkon_pkg::*, renkon_ctrl_pkg::*;
;

  localparam int CORE     = RENKON_CORE;
  localparam int CREDITS  = CREDIT_MAX;
  localparam int LANE_W   = $clog2(CORE);
  localparam int MAX_JOBS = 16;
  localparam int TIMEOUT  = 200000;

  logic                     clk = 1'b0;
  logic                     xrst;
  logic                     req;
  logic                     ack;
  logic [LWIDTH-1:0]        total_in;
  logic [LWIDTH-1:0]        total_out;
  logic [LWIDTH-1:0]        img_size;
  logic [LWIDTH-1:0]        conv_kern;
  logic [IMGSIZE-1:0]       in_offset;
  logic [IMGSIZE-1:0]       out_offset;
  logic [NETSIZE-1:0]       net_offset;
  logic                     net_we;
  logic [LANE_W-1:0]        net_sel;
  logic [NETSIZE-1:0]       net_addr;
  core_state_t              core_state;
  logic [CORE-1:0]          mem_net_we;
  logic [NETSIZE-1:0]       mem_net_addr;
  logic                     wreg_we;
  logic                     breg_we;
  logic                     img_re;
  logic [IMGSIZE-1:0]       img_addr;
  logic                     first_input;
  logic                     last_input;
  logic                     pix_credit = 1'b0;
  logic                     calc_done = 1'b0;
  logic [LANE_W:0]          serial_re;
  logic [OUTSIZE-1:0]       serial_addr;
  logic signed [DWIDTH-1:0] out_wdata = '0;
  logic                     img_we;
  logic signed [DWIDTH-1:0] img_wdata;

  // job table and the job in progress
  int                 job_tab [MAX_JOBS][7];
  int                 njobs;
  int                 cur_in;
  int                 cur_out;
  int                 cur_img;
  int                 cur_kern;
  int                 cur_groups;
  logic [IMGSIZE-1:0] cur_in_off;
  logic [IMGSIZE-1:0] cur_out_off;
  logic [NETSIZE-1:0] cur_net_off;

  // reference model state of the monitor
  logic [NETSIZE-1:0] exp_net_addr;
  logic [IMGSIZE-1:0] exp_in_addr;
  logic [IMGSIZE-1:0] exp_out_addr;
  int                 wreg_total;
  int                 wreg_grp;
  int                 breg_total;
  int                 rd_total;
  int                 rd_grp;
  int                 wr_total;
  int                 wr_grp;
  int                 grp_done;
  int                 outstanding;
  int                 ch;
  int                 fea2;
  int                 valid;
  logic               ack_prev = 1'b1;
  logic               img_we_prev = 1'b0;
  core_state_t        state_prev = S_WAIT;

  // compute side model
  int                 cycle;
  int                 credit_q [$];
  logic [31:0]        rng = 32'h351e42e1;
  core_state_t        state_d = S_WAIT;

  always #50 clk = ~clk;

  renkon_ctrl_core #(.core_num(CORE), .credit_num(CREDITS)) UUT (
    .clk, .xrst, .req, .ack, .total_in, .total_out, .img_size, .conv_kern,
    .in_offset, .out_offset, .net_offset, .net_we, .net_sel, .net_addr,
    .core_state, .mem_net_we, .mem_net_addr, .wreg_we, .breg_we,
    .img_re, .img_addr, .first_input, .last_input, .pix_credit,
    .calc_done, .serial_re, .serial_addr, .out_wdata, .img_we, .img_wdata
  );

  bind renkon_ctrl_input renkon_ctrl_props u_input_props (
    .clk, .xrst, .state, .phase(renkon_ctrl_pkg::S_INPUT), .en(img_re),
    .done(in_end), .level(int'(credit)), .limit(credit_num)
  );

  bind renkon_ctrl_output renkon_ctrl_props u_output_props (
    .clk, .xrst, .state, .phase(renkon_ctrl_pkg::S_OUTPUT), .en(img_we),
    .done(out_end), .level(int'(count_out) + int'(serial_re)),
    .limit(int'(total_out_r))
  );

  // ============================================================
  // compare helpers
  // ============================================================

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_addr(input string name, input logic [IMGSIZE-1:0] exp,
                            input logic [IMGSIZE-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: expected %0h, actual %0h", name, exp, act));
    end
  endtask

  task automatic check_data(input string name, input logic signed [DWIDTH-1:0] exp,
                            input logic signed [DWIDTH-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_state(input string name, input core_state_t exp,
                             input core_state_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: expected %s, actual %s", name, exp.name(), act.name()));
    end
  endtask

  task automatic flag_is(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic lanes_are(input string name, input logic [CORE-1:0] exp,
                           input logic [CORE-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic count_is(input string name, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // ============================================================
  // compute side: credits, done pulse, serial buffer
  // ============================================================

  // DUT outputs read here still hold their pre-edge values
  always @(posedge clk) begin
    if (!xrst) begin
      cycle = 0;
      credit_q.delete();
      state_d = S_WAIT;
      pix_credit <= 1'b0;
      calc_done  <= 1'b0;
      out_wdata  <= '0;
    end else begin
      cycle = cycle + 1;
      if (img_re) begin
        rng = lcg_step(rng);
        credit_q.push_back(cycle + 1 + int'(rng[17:16]));
      end
      if (credit_q.size() > 0 && credit_q[0] <= cycle) begin
        pix_credit <= 1'b1;
        void'(credit_q.pop_front());
      end else begin
        pix_credit <= 1'b0;
      end
      calc_done <= (core_state == S_OUTPUT) && (state_d != S_OUTPUT);
      state_d = core_state;
      if (serial_re != '0) begin
        out_wdata <= DWIDTH'((int'(serial_re) - 1) * 256 + int'(serial_addr));
      end else begin
        out_wdata <= '0;
      end
    end
  end

  // ============================================================
  // monitor
  // ============================================================

  always @(negedge clk) begin
    if (xrst) begin
      fea2 = (cur_img - cur_kern + 1) * (cur_img - cur_kern + 1);
      // ack falling marks the job start
      if (ack_prev && !ack) begin
        exp_net_addr = cur_net_off;
        exp_in_addr  = cur_in_off;
        exp_out_addr = cur_out_off;
        wreg_total   = 0;
        wreg_grp     = 0;
        breg_total   = 0;
        rd_total     = 0;
        rd_grp       = 0;
        wr_total     = 0;
        wr_grp       = 0;
        grp_done     = 0;
        outstanding  = 0;
      end

      // network phase
      if (wreg_we || breg_we) begin
        check_addr("net_addr", IMGSIZE'(exp_net_addr), IMGSIZE'(mem_net_addr));
        exp_net_addr = exp_net_addr + 1'b1;
      end
      if (wreg_we) begin
        wreg_total = wreg_total + 1;
        wreg_grp   = wreg_grp + 1;
      end
      if (breg_we) begin
        count_is("weights_before_bias", cur_in * cur_kern * cur_kern, wreg_grp);
        breg_total = breg_total + 1;
        wreg_grp   = 0;
      end

      // input phase
      if (img_re) begin
        ch = rd_grp / (cur_img * cur_img);
        check_addr("img_read_addr", exp_in_addr, img_addr);
        flag_is("first_input", ch == 0, first_input);
        flag_is("last_input", ch == cur_in - 1, last_input);
        exp_in_addr = exp_in_addr + 1'b1;
        rd_grp      = rd_grp + 1;
        rd_total    = rd_total + 1;
      end
      outstanding = outstanding + int'(img_re) - int'(pix_credit);
      if (outstanding < 0 || outstanding > CREDITS) begin
        abort_run($sformatf("outstanding pixel reads at %0d, outside 0 to %0d",
                            outstanding, CREDITS));
      end

      // output phase
      if (core_state == S_OUTPUT && state_prev != S_OUTPUT) begin
        count_is("reads_per_group", cur_in * cur_img * cur_img, rd_grp);
        rd_grp      = 0;
        exp_in_addr = cur_in_off;
        wr_grp      = 0;
      end
      if (img_we) begin
        check_addr("img_write_addr", exp_out_addr, img_addr);
        check_data("img_wdata", DWIDTH'((wr_grp / fea2) * 256 + wr_grp % fea2), img_wdata);
        exp_out_addr = exp_out_addr + 1'b1;
        wr_grp       = wr_grp + 1;
        wr_total     = wr_total + 1;
      end
      if (state_prev == S_OUTPUT && core_state != S_OUTPUT) begin
        valid = cur_out - grp_done * CORE;
        if (valid > CORE) valid = CORE;
        count_is("writes_per_group", valid * fea2, wr_grp);
        grp_done = grp_done + 1;
      end

      if (!ack_prev && ack) begin
        flag_is("ack_after_last_write", 1'b1, img_we_prev);
      end
      ack_prev    = ack;
      img_we_prev = img_we;
      state_prev  = core_state;
    end
  end

  // ============================================================
  // job sequencing
  // ============================================================

  task automatic load_jobs();
    int    fd;
    int    n;
    int    k;
    int    f [7];
    string line;
    fd = $fopen("renkon_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open renkon_testdata.txt");
    end else begin
      njobs = 0;
      while (!$feof(fd) && njobs < MAX_JOBS) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
          if (n == 7) begin
            for (k = 0; k < 7; k++) job_tab[njobs][k] = f[k];
            njobs = njobs + 1;
          end
        end
      end
      $fclose(fd);
      if (njobs == 0) abort_run("no job lines found in renkon_testdata.txt");
    end
  endtask

  task automatic await_ack(input logic level, input string what);
    int n;
    n = 0;
    while (ack !== level && n < TIMEOUT) begin
      @(negedge clk);
      n = n + 1;
    end
    if (ack !== level) abort_run({"timeout while waiting for ", what});
  endtask

  task automatic run_job(input int j);
    int fea;
    cur_in      = job_tab[j][0];
    cur_out     = job_tab[j][1];
    cur_img     = job_tab[j][2];
    cur_kern    = job_tab[j][3];
    cur_in_off  = IMGSIZE'(job_tab[j][4]);
    cur_out_off = IMGSIZE'(job_tab[j][5]);
    cur_net_off = NETSIZE'(job_tab[j][6]);
    cur_groups  = (cur_out + CORE - 1) / CORE;
    fea         = cur_img - cur_kern + 1;
    @(posedge clk);
    total_in   <= LWIDTH'(cur_in);
    total_out  <= LWIDTH'(cur_out);
    img_size   <= LWIDTH'(cur_img);
    conv_kern  <= LWIDTH'(cur_kern);
    in_offset  <= cur_in_off;
    out_offset <= cur_out_off;
    net_offset <= cur_net_off;
    req        <= 1'b1;
    await_ack(1'b0, "ack to fall at job start");
    @(posedge clk);
    req <= 1'b0;
    await_ack(1'b1, "ack to rise at job end");
    @(posedge clk);
    count_is("weight_writes", cur_groups * cur_in * cur_kern * cur_kern, wreg_total);
    count_is("bias_writes", cur_groups, breg_total);
    count_is("pixel_reads", cur_groups * cur_in * cur_img * cur_img, rd_total);
    count_is("image_writes", cur_out * fea * fea, wr_total);
    count_is("groups_done", cur_groups, grp_done);
    check_state("state_after_job", S_WAIT, core_state);
  endtask

  initial begin
    logic [NETSIZE-1:0] addr_v;
    xrst       = 1'b0;
    req        = 1'b0;
    total_in   = '0;
    total_out  = '0;
    img_size   = '0;
    conv_kern  = '0;
    in_offset  = '0;
    out_offset = '0;
    net_offset = '0;
    net_we     = 1'b0;
    net_sel    = '0;
    net_addr   = '0;
    load_jobs();

    repeat (2) @(posedge clk);
    xrst <= 1'b1;
    @(negedge clk);
    flag_is("ack_after_reset", 1'b1, ack);
    check_state("state_after_reset", S_WAIT, core_state);
    flag_is("wreg_we_after_reset", 1'b0, wreg_we);
    flag_is("breg_we_after_reset", 1'b0, breg_we);
    flag_is("img_re_after_reset", 1'b0, img_re);
    flag_is("img_we_after_reset", 1'b0, img_we);
    flag_is("first_input_after_reset", 1'b0, first_input);
    flag_is("last_input_after_reset", 1'b0, last_input);
    count_is("serial_re_after_reset", 0, int'(serial_re));
    lanes_are("mem_net_we_after_reset", '0, mem_net_we);

    // host load of every lane
    for (int i = 0; i < CORE; i++) begin
      addr_v = NETSIZE'(32'h123 + i * 32'h0a5);
      @(posedge clk);
      net_we   <= 1'b1;
      net_sel  <= LANE_W'(i);
      net_addr <= addr_v;
      @(negedge clk);
      lanes_are("net_load_we", CORE'(1) << i, mem_net_we);
      check_addr("net_load_addr", IMGSIZE'(addr_v), IMGSIZE'(mem_net_addr));
    end
    @(posedge clk);
    net_we <= 1'b0;
    @(negedge clk);
    lanes_are("net_load_idle", '0, mem_net_we);

    for (int j = 0; j < njobs; j++) begin
      run_job(j);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- renkon_ctrl_props.sv
`timescale 1ns/1ps

module renkon_ctrl_props
  import renkon_ctrl_pkg::*;
(
  input logic        clk,
  input logic        xrst,
  input core_state_t state,
  input core_state_t phase,
  input logic        en,
  input logic        done,
  input int          level,
  input int          limit
);

  // memory strobe only inside the phase that owns it
  a_en_in_phase: assert property (
    @(posedge clk) disable iff (!xrst) en |-> state == phase
  ) else $error("memory strobe active outside its phase");

  // credit count or channel of the lane being read stays within its bound
  a_level_bound: assert property (
    @(posedge clk) disable iff (!xrst) level <= limit
  ) else $error("counter above its limit");

  // phase end hands over to the next state
  a_done_leaves: assert property (
    @(posedge clk) disable iff (!xrst) done |=> state != phase
  ) else $error("FSM still in the phase after its end pulse");

endmodule

//--- renkon_ctrl_core.sv
`timescale 1ns/1ps

module renkon_ctrl_core
  import renkon_pkg::*, renkon_ctrl_pkg::*;
#(
  parameter int core_num   = RENKON_CORE,
  parameter int credit_num = CREDIT_MAX
) (
  input  logic                          clk,
  input  logic                          xrst,
  // host side
  input  logic                          req,
  output logic                          ack,
  input  logic [LWIDTH-1:0]             total_in,
  input  logic [LWIDTH-1:0]             total_out,
  input  logic [LWIDTH-1:0]             img_size,
  input  logic [LWIDTH-1:0]             conv_kern,
  input  logic [IMGSIZE-1:0]            in_offset,
  input  logic [IMGSIZE-1:0]            out_offset,
  input  logic [NETSIZE-1:0]            net_offset,
  input  logic                          net_we,
  input  logic [$clog2(core_num)-1:0]   net_sel,
  input  logic [NETSIZE-1:0]            net_addr,
  output core_state_t                   core_state,
  // network memory and weight registers
  output logic [core_num-1:0]           mem_net_we,
  output logic [NETSIZE-1:0]            mem_net_addr,
  output logic                          wreg_we,
  output logic                          breg_we,
  // pixel stream
  output logic                          img_re,
  output logic [IMGSIZE-1:0]            img_addr,
  output logic                          first_input,
  output logic                          last_input,
  input  logic                          pix_credit,
  // compute array and serial buffer
  input  logic                          calc_done,
  output logic [$clog2(core_num):0]     serial_re,
  output logic [OUTSIZE-1:0]            serial_addr,
  input  logic signed [DWIDTH-1:0]      out_wdata,
  // image write-back
  output logic                          img_we,
  output logic signed [DWIDTH-1:0]      img_wdata
);

  logic               job_start;
  logic               last_in;
  logic [LWIDTH-1:0]  count_out;
  logic [LWIDTH-1:0]  img_size_r;
  logic [LWIDTH-1:0]  kern_r;
  logic [LWIDTH-1:0]  total_out_r;
  logic               net_end;
  logic               in_end;
  logic               out_end;
  logic [IMGSIZE-1:0] img_addr_in;
  logic [IMGSIZE-1:0] img_addr_out;

  // only one phase drives the image bus at a time
  assign img_addr = (core_state == S_INPUT) ? img_addr_in : img_addr_out;

  renkon_ctrl_seq #(.core_num(core_num)) u_seq (
    .clk, .xrst, .req, .total_in, .total_out, .img_size, .conv_kern,
    .net_end, .in_end, .out_end,
    .state(core_state), .job_start, .last_in, .count_out,
    .img_size_r, .kern_r, .total_out_r, .ack
  );

  renkon_ctrl_net #(.core_num(core_num)) u_net (
    .clk, .xrst, .state(core_state), .last_in, .job_start, .kern_r,
    .net_offset, .net_we, .net_sel, .net_addr,
    .net_end, .wreg_we, .breg_we, .mem_net_we, .mem_net_addr
  );

  renkon_ctrl_input #(.credit_num(credit_num)) u_input (
    .clk, .xrst, .state(core_state), .job_start, .last_in, .img_size_r,
    .in_offset, .pix_credit,
    .in_end, .img_re, .img_addr_in, .first_input, .last_input
  );

  renkon_ctrl_output #(.core_num(core_num)) u_output (
    .clk, .xrst, .state(core_state), .job_start, .calc_done, .count_out,
    .total_out_r, .img_size_r, .kern_r, .out_offset, .out_wdata,
    .out_end, .serial_re, .serial_addr, .img_we, .img_addr_out, .img_wdata
  );

endmodule

//--- renkon_ctrl_output.sv
`timescale 1ns/1ps

module renkon_ctrl_output
  import renkon_pkg::*, renkon_ctrl_pkg::*;
#(
  parameter int core_num = RENKON_CORE
) (
  input  logic                     clk,
  input  logic                     xrst,
  input  core_state_t              state,
  input  logic                     job_start,
  input  logic                     calc_done,
  input  logic [LWIDTH-1:0]        count_out,
  input  logic [LWIDTH-1:0]        total_out_r,
  input  logic [LWIDTH-1:0]        img_size_r,
  input  logic [LWIDTH-1:0]        kern_r,
  input  logic [IMGSIZE-1:0]       out_offset,
  input  logic signed [DWIDTH-1:0] out_wdata,
  output logic                     out_end,
  output logic [$clog2(core_num):0] serial_re,
  output logic [OUTSIZE-1:0]       serial_addr,
  output logic                     img_we,
  output logic [IMGSIZE-1:0]       img_addr_out,
  output logic signed [DWIDTH-1:0] img_wdata
);

  localparam int LANE_W = $clog2(core_num);

  logic [LWIDTH-1:0]   fea_size;
  logic [2*LWIDTH-1:0] npix;
  logic [LWIDTH-1:0]   next_ch;
  logic [LANE_W-1:0]   lane;
  logic                busy;
  logic                addr_last;
  logic                lane_last;
  logic                rd_last;

  // ============================================================
  // lane and address walk
  // ============================================================

  // no padding, unit stride
  assign fea_size  = img_size_r - kern_r + 1'b1;
  assign npix      = fea_size * fea_size;
  assign addr_last = {{(2*LWIDTH-OUTSIZE){1'b0}}, serial_addr} == npix - 1'b1;

  // lanes past total_out are never read
  assign next_ch   = count_out + LWIDTH'(lane) + 1'b1;
  assign lane_last = (lane == LANE_W'(core_num - 1)) || (next_ch >= total_out_r);
  assign rd_last   = busy && addr_last && lane_last;

  // lane number plus one, zero when idle
  assign serial_re = busy ? {1'b0, lane} + 1'b1 : '0;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      busy        <= 1'b0;
      lane        <= '0;
      serial_addr <= '0;
    end else if (busy) begin
      if (addr_last) begin
        serial_addr <= '0;
        if (lane_last) begin
          busy <= 1'b0;
          lane <= '0;
        end else begin
          lane <= lane + 1'b1;
        end
      end else begin
        serial_addr <= serial_addr + 1'b1;
      end
    end else if (state == S_OUTPUT && calc_done) begin
      busy <= 1'b1;
    end
  end

  // ============================================================
  // image write-back
  // ============================================================

  // serial data comes back one cycle after the read
  assign img_wdata = out_wdata;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      img_we  <= 1'b0;
      out_end <= 1'b0;
    end else begin
      img_we  <= busy;
      out_end <= rd_last;
    end
  end

  // write address spans the whole job
  always_ff @(posedge clk) begin
    if (!xrst) begin
      img_addr_out <= '0;
    end else if (job_start) begin
      img_addr_out <= out_offset;
    end else if (img_we) begin
      img_addr_out <= img_addr_out + 1'b1;
    end
  end

endmodule

//--- renkon_ctrl_input.sv
`timescale 1ns/1ps

module renkon_ctrl_input
  import renkon_pkg::*, renkon_ctrl_pkg::*;
#(
  parameter int credit_num = CREDIT_MAX
) (
  input  logic               clk,
  input  logic               xrst,
  input  core_state_t        state,
  input  logic               job_start,
  input  logic               last_in,
  input  logic [LWIDTH-1:0]  img_size_r,
  input  logic [IMGSIZE-1:0] in_offset,
  input  logic               pix_credit,
  output logic               in_end,
  output logic               img_re,
  output logic [IMGSIZE-1:0] img_addr_in,
  output logic               first_input,
  output logic               last_input
);

  localparam int CW = $clog2(credit_num + 1);

  logic [CW-1:0]       credit;
  logic [2*LWIDTH-1:0] npix;
  logic [2*LWIDTH-1:0] pix_cnt;
  logic                pix_last;
  logic                first_ch;
  logic [IMGSIZE-1:0]  in_offset_r;

  assign npix     = img_size_r * img_size_r;
  assign pix_last = pix_cnt == npix - 1'b1;

  // no read in the end cycle, the phase is over
  assign img_re      = (state == S_INPUT) && !in_end && (credit != '0);
  assign first_input = img_re && first_ch;
  assign last_input  = img_re && last_in;

  // ============================================================
  // credit counter
  // ============================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      credit <= '0;
    end else if (job_start) begin
      credit <= CW'(credit_num);
    end else if (img_re && !pix_credit) begin
      credit <= credit - 1'b1;
    end else if (!img_re && pix_credit) begin
      credit <= credit + 1'b1;
    end
  end

  // pixels of the current channel
  always_ff @(posedge clk) begin
    if (!xrst || job_start) begin
      pix_cnt <= '0;
      in_end  <= 1'b0;
    end else begin
      in_end <= img_re && pix_last;
      if (img_re) begin
        pix_cnt <= pix_last ? '0 : pix_cnt + 1'b1;
      end
    end
  end

  // read address restarts at each group
  always_ff @(posedge clk) begin
    if (!xrst) begin
      img_addr_in <= '0;
      first_ch    <= 1'b0;
    end else if (job_start) begin
      img_addr_in <= in_offset;
      first_ch    <= 1'b1;
    end else if (state == S_OUTPUT) begin
      img_addr_in <= in_offset_r;
      first_ch    <= 1'b1;
    end else begin
      if (img_re) img_addr_in <= img_addr_in + 1'b1;
      if (in_end) first_ch <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (job_start) begin
      in_offset_r <= in_offset;
    end
  end

endmodule

//--- renkon_ctrl_net.sv
`timescale 1ns/1ps

module renkon_ctrl_net
  import renkon_pkg::*, renkon_ctrl_pkg::*;
#(
  parameter int core_num = RENKON_CORE
) (
  input  logic                        clk,
  input  logic                        xrst,
  input  core_state_t                 state,
  input  logic                        last_in,
  input  logic                        job_start,
  input  logic [LWIDTH-1:0]           kern_r,
  input  logic [NETSIZE-1:0]          net_offset,
  input  logic                        net_we,
  input  logic [$clog2(core_num)-1:0] net_sel,
  input  logic [NETSIZE-1:0]          net_addr,
  output logic                        net_end,
  output logic                        wreg_we,
  output logic                        breg_we,
  output logic [core_num-1:0]         mem_net_we,
  output logic [NETSIZE-1:0]          mem_net_addr
);

  weight_state_t      wstate;
  logic               host_we;
  logic               weight_end;
  logic [LWIDTH-1:0]  weight_x;
  logic [LWIDTH-1:0]  weight_y;
  logic [NETSIZE-1:0] net_cnt;
  logic [NETSIZE-1:0] net_offset_r;

  assign wreg_we    = (state == S_NETWORK) && (wstate == S_W_WEIGHT);
  assign breg_we    = (state == S_NETWORK) && (wstate == S_W_BIAS);
  assign weight_end = wreg_we && weight_x == kern_r - 1'b1 && weight_y == kern_r - 1'b1;
  // bias word only after the last input channel
  assign net_end    = (weight_end && !last_in) || breg_we;

  // host load only while idle
  assign host_we = net_we && (state == S_WAIT);

  for (genvar i = 0; i < core_num; i++) begin : g_lane_we
    assign mem_net_we[i] = host_we && (net_sel == ($clog2(core_num))'(i));
  end

  assign mem_net_addr = host_we ? net_addr : net_offset_r + net_cnt;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wstate <= S_W_WEIGHT;
    end else if (job_start) begin
      wstate <= S_W_WEIGHT;
    end else begin
      case (wstate)
        S_W_WEIGHT: if (weight_end && last_in) wstate <= S_W_BIAS;
        S_W_BIAS:   if (breg_we) wstate <= S_W_WEIGHT;
        default:    wstate <= S_W_WEIGHT;
      endcase
    end
  end

  // kernel raster position
  always_ff @(posedge clk) begin
    if (!xrst || job_start) begin
      weight_x <= '0;
      weight_y <= '0;
    end else if (wreg_we) begin
      if (weight_x == kern_r - 1'b1) begin
        weight_x <= '0;
        weight_y <= (weight_y == kern_r - 1'b1) ? '0 : weight_y + 1'b1;
      end else begin
        weight_x <= weight_x + 1'b1;
      end
    end
  end

  // runs over all channels and groups of the job
  always_ff @(posedge clk) begin
    if (!xrst || job_start) begin
      net_cnt <= '0;
    end else if (wreg_we || breg_we) begin
      net_cnt <= net_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (job_start) begin
      net_offset_r <= net_offset;
    end
  end

endmodule

//--- renkon_ctrl_seq.sv
`timescale 1ns/1ps

module renkon_ctrl_seq
  import renkon_pkg::*, renkon_ctrl_pkg::*;
#(
  parameter int core_num = RENKON_CORE
) (
  input  logic              clk,
  input  logic              xrst,
  input  logic              req,
  input  logic [LWIDTH-1:0] total_in,
  input  logic [LWIDTH-1:0] total_out,
  input  logic [LWIDTH-1:0] img_size,
  input  logic [LWIDTH-1:0] conv_kern,
  input  logic              net_end,
  input  logic              in_end,
  input  logic              out_end,
  output core_state_t       state,
  output logic              job_start,
  output logic              last_in,
  output logic [LWIDTH-1:0] count_out,
  output logic [LWIDTH-1:0] img_size_r,
  output logic [LWIDTH-1:0] kern_r,
  output logic [LWIDTH-1:0] total_out_r,
  output logic              ack
);

  logic              req_r;
  logic              req_edge;
  logic              last_grp;
  logic [LWIDTH-1:0] total_in_r;
  logic [LWIDTH-1:0] count_in;

  // ============================================================
  // job start detection
  // ============================================================

  assign req_edge  = req && !req_r;
  assign job_start = (state == S_WAIT) && req_edge;

  assign last_in  = count_in == total_in_r - 1'b1;
  // one extra bit so the group step cannot wrap
  assign last_grp = {1'b0, count_out} + (LWIDTH+1)'(core_num) >= {1'b0, total_out_r};

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_r <= 1'b0;
    end else begin
      req_r <= req;
    end
  end

  // layer parameters, held for the whole job
  always_ff @(posedge clk) begin
    if (job_start) begin
      total_in_r  <= total_in;
      total_out_r <= total_out;
      img_size_r  <= img_size;
      kern_r      <= conv_kern;
    end
  end

  // ============================================================
  // main FSM
  // ============================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= S_WAIT;
      count_in  <= '0;
      count_out <= '0;
    end else begin
      case (state)
        S_WAIT: begin
          if (req_edge) begin
            state     <= S_NETWORK;
            count_in  <= '0;
            count_out <= '0;
          end
        end
        S_NETWORK: begin
          if (net_end) begin
            state <= S_INPUT;
          end
        end
        S_INPUT: begin
          if (in_end) begin
            if (last_in) begin
              state    <= S_OUTPUT;
              count_in <= '0;
            end else begin
              state    <= S_NETWORK;
              count_in <= count_in + 1'b1;
            end
          end
        end
        S_OUTPUT: begin
          // next group of lanes, or back to idle
          if (out_end) begin
            if (last_grp) begin
              state     <= S_WAIT;
              count_out <= '0;
            end else begin
              state     <= S_NETWORK;
              count_out <= count_out + LWIDTH'(core_num);
            end
          end
        end
        default: state <= S_WAIT;
      endcase
    end
  end

  // ack low for the duration of the job
  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack <= 1'b1;
    end else if (job_start) begin
      ack <= 1'b0;
    end else if (state == S_OUTPUT && out_end && last_grp) begin
      ack <= 1'b1;
    end
  end

endmodule

//--- renkon_ctrl_pkg.sv
package renkon_ctrl_pkg;

  // main sequencer state
  typedef enum logic [1:0] {
    S_WAIT    = 2'd0,
    S_NETWORK = 2'd1,
    S_INPUT   = 2'd2,
    S_OUTPUT  = 2'd3
  } core_state_t;

  // network phase sub-state
  typedef enum logic {
    S_W_WEIGHT = 1'b0,
    S_W_BIAS   = 1'b1
  } weight_state_t;

endpackage

//--- renkon_pkg.sv
package renkon_pkg;

  // ============================================================
  // accelerator sizing
  // ============================================================

  // number of compute lanes
  localparam int RENKON_CORE = 8;

  // data path
  localparam int DWIDTH      = 16;
  localparam int LWIDTH      = 10;

  // memory address widths
  localparam int IMGSIZE     = 12;
  localparam int NETSIZE     = 11;
  localparam int OUTSIZE     = 8;

  // outstanding pixel reads
  localparam int CREDIT_MAX  = 4;

endpackage
